//--- Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -j 0
TOP       ?= tb_exec_cluster
FILELIST  ?= filelist.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)
	./$(BUILD_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	@if grep -q "Result: FAILED" $(LOG); then \
		echo "simulation failed"; \
		exit 1; \
	fi
	@grep -q "Result: PASSED" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

//--- bench/tb_clkgen.sv
// testbench clock and reset generator.
//  - free-running clock, 4 ns period.
//  - active-low reset held for the first 3 rising edges.
`timescale 1ns/1ps
`default_nettype none

module tb_clkgen #(
    parameter int PERIOD_NS    = 4,
    parameter int RESET_CYCLES = 3
) (
    output logic clk_o,
    output logic rstn_o
);

    initial begin
        clk_o = 1'b0;
        forever #(PERIOD_NS / 2) clk_o = ~clk_o; // half period per toggle.
    end

    initial begin
        rstn_o = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk_o);
        rstn_o <= 1'b1; // released after the last reset edge.
    end

endmodule

`default_nettype wire

//--- bench/tb_exec_cluster.sv
// testbench of the integer execute cluster.
//  - shadow register file and result model per ALU operation.
//  - completion monitor checking dst, data and fixed latency.
//  - 16-bit Fibonacci LFSR for operand data.
//  - directed tests: reset, operation set, register 0, bypass, parallel writeback.
`timescale 1ns/1ps
`default_nettype none

module tb_exec_cluster;

    localparam int NUM_LANES = 2;
    localparam int NUM_PREGS = 64;
    localparam int PREG_W    = $clog2(NUM_PREGS);
    localparam int LANE_W    = 1;
    localparam int XLEN      = exec_pkg::XLEN;
    localparam int TIMEOUT   = 40; // cycles allowed for any single wait.

    logic                                clk;
    logic                                rstn;
    logic                                issue_valid_i;
    exec_pkg::alu_op_t                   issue_op_i;
    logic [LANE_W-1:0]                   issue_lane_i;
    logic [PREG_W-1:0]                   issue_src1_i;
    logic [PREG_W-1:0]                   issue_src2_i;
    logic [PREG_W-1:0]                   issue_dst_i;
    logic [NUM_LANES-1:0]                complete_valid_o;
    logic [NUM_LANES-1:0][PREG_W-1:0]    complete_dst_o;
    logic [NUM_LANES-1:0][XLEN-1:0]      complete_data_o;

    logic [XLEN-1:0] shadow [NUM_PREGS]; // model of the register file.
    logic [15:0]     lfsr_q = 16'd33386;
    int              cyc = 0;            // rising edges seen so far.
    int              last_done [NUM_LANES];
    int              error_count = 0;
    int              timeout_count = 0;
    int              check_count = 0;

    // instructions in flight, one entry per issue.
    int              pend_lane [$];
    logic [PREG_W-1:0] pend_dst [$];
    logic [XLEN-1:0] pend_data [$];
    int              pend_edge [$];      // edge at which the issue was sampled.
    int              pend_lat [$];

    tb_clkgen #(.PERIOD_NS(4), .RESET_CYCLES(3)) clkgen_i (.clk_o(clk), .rstn_o(rstn));

    exec_cluster #(
        .NUM_LANES (NUM_LANES),
        .NUM_PREGS (NUM_PREGS)
    ) dut_i (
        .clk_i            (clk),
        .rstn_i           (rstn),
        .issue_valid_i    (issue_valid_i),
        .issue_op_i       (issue_op_i),
        .issue_lane_i     (issue_lane_i),
        .issue_src1_i     (issue_src1_i),
        .issue_src2_i     (issue_src2_i),
        .issue_dst_i      (issue_dst_i),
        .complete_valid_o (complete_valid_o),
        .complete_dst_o   (complete_dst_o),
        .complete_data_o  (complete_data_o)
    );

    always @(posedge clk) cyc <= cyc + 1;

    // one LFSR step per bit, taps 16, 14, 13, 11.
    function automatic logic [XLEN-1:0] rand_bits(input int nbits);
        logic [XLEN-1:0] val;
        logic            fb;
        val = '0;
        for (int i = 0; i < nbits; i++) begin
            fb     = lfsr_q[15] ^ lfsr_q[13] ^ lfsr_q[12] ^ lfsr_q[10];
            lfsr_q = {lfsr_q[14:0], fb};
            val    = {val[XLEN-2:0], fb};
        end
        return val;
    endfunction

    // result of each operation as the ISA defines it.
    function automatic logic [XLEN-1:0] expected_result(input exec_pkg::alu_op_t op,
                                                        input logic [XLEN-1:0] a,
                                                        input logic [XLEN-1:0] b);
        case (op)
            exec_pkg::ADD: return a + b;
            exec_pkg::SUB: return a - b;
            exec_pkg::AND: return a & b;
            exec_pkg::OR:  return a | b;
            exec_pkg::XOR: return a ^ b;
            exec_pkg::SLL: return a << b[5:0]; // low 6 bits only.
            exec_pkg::SRL: return a >> b[5:0];
            default:       return a * b;       // low half of the product.
        endcase
    endfunction

    // drive one instruction now, return at the edge that samples it.
    task automatic issue(input exec_pkg::alu_op_t op, input int lane, input int dst,
                         input int src1, input int src2);
        logic [XLEN-1:0] a;
        logic [XLEN-1:0] b;
        issue_valid_i <= 1'b1;
        issue_op_i    <= op;
        issue_lane_i  <= LANE_W'(lane);
        issue_src1_i  <= PREG_W'(src1);
        issue_src2_i  <= PREG_W'(src2);
        issue_dst_i   <= PREG_W'(dst);
        @(posedge clk);
        a = shadow[src1]; // includes a completion of this very cycle.
        b = shadow[src2];
        pend_lane.push_back(lane);
        pend_dst.push_back(PREG_W'(dst));
        pend_data.push_back(expected_result(op, a, b));
        pend_edge.push_back(cyc + 1);
        pend_lat.push_back((op == exec_pkg::MUL) ? 4 : 3);
        issue_valid_i <= 1'b0;
    endtask

    task automatic step(input int n);
        repeat (n) @(posedge clk);
    endtask

    // backdoor load of a storage entry, between two edges.
    task automatic preload(input int r, input logic [XLEN-1:0] val);
        @(negedge clk);
        dut_i.regfile_i.regs_q[r] <= val;
        shadow[r] = val;
        @(posedge clk);
    endtask

    task automatic wait_reset();
        int n;
        n = 0;
        while (rstn !== 1'b1 && n < TIMEOUT) begin
            @(posedge clk);
            n++;
        end
        if (rstn !== 1'b1) begin
            $display("reset was not released within %0d cycles", TIMEOUT);
            timeout_count++;
        end
    endtask

    task automatic wait_drain();
        int n;
        n = 0;
        while (pend_lane.size() > 0 && n < TIMEOUT) begin
            @(posedge clk);
            n++;
        end
        if (pend_lane.size() > 0) begin
            $display("%0d issued instructions never completed within %0d cycles",
                     pend_lane.size(), TIMEOUT);
            timeout_count++;
            pend_lane.delete();
            pend_dst.delete();
            pend_data.delete();
            pend_edge.delete();
            pend_lat.delete();
        end
    endtask

    // match a completion with the oldest instruction issued to that lane.
    task automatic check_completion(input int k);
        int idx;
        int lat;
        idx = -1;
        for (int i = 0; i < pend_lane.size(); i++) begin
            if (idx < 0 && pend_lane[i] == k) idx = i;
        end
        last_done[k] = cyc + 1; // the next edge samples this completion.
        if (idx < 0) begin
            error_count++;
            $display("lane %0d reported a completion that was never issued, at %0t", k, $time);
        end else begin
            lat = cyc + 1 - pend_edge[idx];
            check_count += 3;
            if (complete_dst_o[k] !== pend_dst[idx]) begin
                error_count++;
                $display("error at %0t: complete_dst_o[%0d] expected %0d, got %0d",
                         $time, k, pend_dst[idx], complete_dst_o[k]);
            end
            if (complete_data_o[k] !== pend_data[idx]) begin
                error_count++;
                $display("error at %0t: complete_data_o[%0d] expected %h, got %h",
                         $time, k, pend_data[idx], complete_data_o[k]);
            end
            if (lat != pend_lat[idx]) begin
                error_count++;
                $display("error at %0t: latency of complete_valid_o[%0d] expected %0d, got %0d",
                         $time, k, pend_lat[idx], lat);
            end
            if (pend_dst[idx] != '0) shadow[pend_dst[idx]] = pend_data[idx]; // r0 stays zero.
            pend_lane.delete(idx);
            pend_dst.delete(idx);
            pend_data.delete(idx);
            pend_edge.delete(idx);
            pend_lat.delete(idx);
        end
    endtask

    // completions are sampled mid-cycle, where they are stable.
    initial begin
        forever begin
            @(negedge clk);
            if (rstn === 1'b1) begin
                for (int k = 0; k < NUM_LANES; k++) begin
                    if (complete_valid_o[k] === 1'b1) check_completion(k);
                end
            end
        end
    end

    task automatic test_reset_state();
        for (int i = 0; i < 3; i++) begin
            @(negedge clk);
            check_count++;
            if (complete_valid_o !== '0) begin
                error_count++;
                $display("error at %0t: complete_valid_o expected %b, got %b",
                         $time, NUM_LANES'(0), complete_valid_o);
            end
        end
        @(posedge clk);
        issue(exec_pkg::OR, 0, 7, 5, 0);   // zero after reset.
        issue(exec_pkg::ADD, 1, 9, 12, 33);
        wait_drain();
    endtask

    task automatic test_op_set();
        exec_pkg::alu_op_t op;
        for (int i = 0; i < 16; i++) begin
            op = exec_pkg::alu_op_t'(3'(i % 8));
            preload(10, rand_bits(XLEN));
            preload(11, rand_bits(XLEN));
            issue(exec_pkg::ADD, 0, 20, 10, 0); // read back both operands.
            issue(exec_pkg::ADD, 1, 21, 0, 11);
            wait_drain();
            issue(op, i / 8, 40 + i, 10, 11);  // every op once on each lane.
            wait_drain();
        end
    endtask

    task automatic test_zero_reg();
        preload(3, rand_bits(XLEN));
        issue(exec_pkg::ADD, 1, 0, 3, 3);  // completes, write dropped.
        step(2);
        issue(exec_pkg::OR, 0, 4, 0, 0);   // r0 read while the r0 write is on the port.
        wait_drain();
        issue(exec_pkg::ADD, 1, 5, 0, 3);
        issue(exec_pkg::XOR, 0, 6, 3, 0);
        wait_drain();
    endtask

    task automatic test_bypass();
        preload(20, rand_bits(XLEN));
        preload(21, rand_bits(XLEN));
        issue(exec_pkg::ADD, 0, 22, 20, 21);
        step(2);
        issue(exec_pkg::SUB, 1, 23, 22, 20); // same cycle as r22 completes.
        step(6);
        issue(exec_pkg::XOR, 0, 24, 21, 22); // r22 from storage.
        wait_drain();
        issue(exec_pkg::MUL, 1, 25, 20, 21);
        step(3);
        issue(exec_pkg::AND, 0, 26, 25, 25); // both ports bypass the product.
        wait_drain();
    endtask

    task automatic test_parallel_wb();
        int mul_edge;
        preload(30, rand_bits(XLEN));
        preload(31, rand_bits(XLEN));
        issue(exec_pkg::MUL, 0, 32, 30, 31);
        mul_edge = pend_edge[pend_edge.size() - 1];
        issue(exec_pkg::ADD, 1, 33, 30, 31); // lands in the same cycle as the MUL.
        wait_drain();
        for (int k = 0; k < NUM_LANES; k++) begin
            check_count++;
            if (last_done[k] != mul_edge + 4) begin
                error_count++;
                $display("error at %0t: edge of complete_valid_o[%0d] expected %0d, got %0d",
                         $time, k, mul_edge + 4, last_done[k]);
            end
        end
        issue(exec_pkg::OR, 0, 34, 32, 0);
        issue(exec_pkg::OR, 1, 35, 0, 33);
        wait_drain();
    endtask

    initial begin
        issue_valid_i = 1'b0;
        issue_op_i    = exec_pkg::ADD;
        issue_lane_i  = '0;
        issue_src1_i  = '0;
        issue_src2_i  = '0;
        issue_dst_i   = '0;
        for (int r = 0; r < NUM_PREGS; r++) shadow[r] = '0;
        wait_reset();
        test_reset_state();
        test_op_set();
        test_zero_reg();
        test_bypass();
        test_parallel_wb();
        step(4);
        $display("checks: %0d, errors: %0d, timeouts: %0d",
                 check_count, error_count, timeout_count);
        if (error_count == 0 && timeout_count == 0) begin
            $display("Result: PASSED");
        end else begin
            $display("Result: FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- common/exec_pkg.sv
// shared definitions of the integer execute cluster.
//  - XLEN, the datapath width.
//  - alu_op_t, the 3-bit ALU operation encoding.
//  - op_is_long(), the latency class of an operation.
`default_nettype none

package exec_pkg;

    // datapath width of every operand and result.
    parameter int XLEN = 64;

    // ALU operations. shifts use the low log2(XLEN) bits of source 2.
    typedef enum logic [2:0] {
        ADD = 3'd0, // a + b.
        SUB = 3'd1, // a - b.
        AND = 3'd2, // bitwise and.
        OR  = 3'd3, // bitwise or.
        XOR = 3'd4, // bitwise xor.
        SLL = 3'd5, // shift left logical.
        SRL = 3'd6, // shift right logical.
        MUL = 3'd7  // low XLEN bits of the product.
    } alu_op_t;

    // true for operations that need the second lane stage.
    // only the multiply is long today.
    function automatic logic op_is_long(input alu_op_t op);
        return (op == MUL);
    endfunction

endpackage

`default_nettype wire

//--- filelist.f
common/exec_pkg.sv
regfile/phys_regfile.sv
rtl/operand_fetch.sv
rtl/alu_lane.sv
rtl/writeback_unit.sv
rtl/exec_cluster.sv
bench/tb_clkgen.sv
bench/tb_exec_cluster.sv

//--- regfile/phys_regfile.sv
// physical register file of the execute cluster.
//  - NUM_WB write ports, one per ALU lane.
//  - two combinational read ports with same-cycle write bypass.
//  - register 0 hardwired to zero, never stored.
//  - check on colliding write ports.
`timescale 1ns/1ps
`default_nettype none

module phys_regfile #(
    parameter int NUM_PREGS = 64,
    parameter int NUM_WB    = 2,
    localparam int PREG_W   = $clog2(NUM_PREGS)
) (
    input  logic                                  clk_i,
    input  logic                                  rstn_i,
    // write ports, fed by the writeback unit.
    input  logic [NUM_WB-1:0]                     write_enable_i,
    input  logic [NUM_WB-1:0][PREG_W-1:0]         write_addr_i,
    input  logic [NUM_WB-1:0][exec_pkg::XLEN-1:0] write_data_i,
    // read ports, addressed by operand fetch.
    input  logic [PREG_W-1:0]                     read_addr1_i,
    input  logic [PREG_W-1:0]                     read_addr2_i,
    output logic [exec_pkg::XLEN-1:0]             read_data1_o,
    output logic [exec_pkg::XLEN-1:0]             read_data2_o
);

    // storage starts at 1, register 0 has no flops.
    logic [exec_pkg::XLEN-1:0] regs_q [NUM_PREGS-1:1];

    logic [exec_pkg::XLEN-1:0] byp_data1; // or of matching write data, port 1.
    logic [exec_pkg::XLEN-1:0] byp_data2; // same for port 2.
    logic                      byp_hit1;
    logic                      byp_hit2;

    // bypass search over all write ports.
    // at most one port matches a nonzero address, so or-ing is a mux.
    always_comb begin
        byp_data1 = '0;
        byp_data2 = '0;
        byp_hit1  = 1'b0;
        byp_hit2  = 1'b0;
        for (int i = 0; i < NUM_WB; i++) begin
            if (write_enable_i[i] && (write_addr_i[i] == read_addr1_i)) begin
                byp_data1 = byp_data1 | write_data_i[i];
                byp_hit1  = 1'b1;
            end
            if (write_enable_i[i] && (write_addr_i[i] == read_addr2_i)) begin
                byp_data2 = byp_data2 | write_data_i[i];
                byp_hit2  = 1'b1;
            end
        end
    end

    // read select: zero register, then bypass, then storage.
    always_comb begin
        if (read_addr1_i == '0) begin
            read_data1_o = '0;
        end else if (byp_hit1) begin
            read_data1_o = byp_data1;
        end else begin
            read_data1_o = regs_q[read_addr1_i];
        end

        if (read_addr2_i == '0) begin
            read_data2_o = '0;
        end else if (byp_hit2) begin
            read_data2_o = byp_data2;
        end else begin
            read_data2_o = regs_q[read_addr2_i];
        end
    end

    // write ports; writes to register 0 are dropped here.
    always_ff @(posedge clk_i) begin
        if (!rstn_i) begin
            for (int r = 1; r < NUM_PREGS; r++) begin
                regs_q[r] <= '0; // all registers read zero after reset.
            end
        end else begin
            for (int i = 0; i < NUM_WB; i++) begin
                if (write_enable_i[i] && (write_addr_i[i] != '0)) begin
                    regs_q[write_addr_i[i]] <= write_data_i[i];
                end
            end
        end
    end

    // two lanes completing to the same register would lose one result.
    for (genvar i = 0; i < NUM_WB; i++) begin : g_wr_chk_i
        for (genvar j = i + 1; j < NUM_WB; j++) begin : g_wr_chk_j
            a_no_wr_collision: assert property (@(posedge clk_i) disable iff (!rstn_i)
                !(write_enable_i[i] && write_enable_i[j] &&
                  (write_addr_i[i] == write_addr_i[j]) && (write_addr_i[i] != '0)))
                else $error("write ports %0d and %0d hit register %0d",
                            i, j, write_addr_i[i]);
        end
    end

endmodule

`default_nettype wire

//--- rtl/alu_lane.sv
// two-stage integer ALU lane.
//  - stage one: add, sub, logic ops and shifts, finishing in one cycle.
//  - stage two: multiply, product registered after stage one.
//  - one output register shared by both stages.
`timescale 1ns/1ps
`default_nettype none

module alu_lane #(
    parameter int NUM_PREGS = 64,
    localparam int PREG_W   = $clog2(NUM_PREGS)
) (
    input  logic                      clk_i,
    input  logic                      rstn_i,
    // lane input slot from operand fetch.
    input  logic                      valid_i,
    input  exec_pkg::alu_op_t         op_i,
    input  logic [exec_pkg::XLEN-1:0] a_i,
    input  logic [exec_pkg::XLEN-1:0] b_i,
    input  logic [PREG_W-1:0]         dst_i,
    // result register towards writeback.
    output logic                      res_valid_o,
    output logic [PREG_W-1:0]         res_dst_o,
    output logic [exec_pkg::XLEN-1:0] res_data_o
);

    localparam int SHAMT_W = $clog2(exec_pkg::XLEN); // 6 for 64-bit data.

    logic                      short_done;   // single-cycle op finishes now.
    logic [exec_pkg::XLEN-1:0] short_result; // stage one result.
    logic [exec_pkg::XLEN-1:0] mul_lo;       // low half of a_i * b_i.
    logic [SHAMT_W-1:0]        shamt;

    logic                      mul_valid_q;  // stage two holds a multiply.
    logic [PREG_W-1:0]         mul_dst_q;
    logic [exec_pkg::XLEN-1:0] mul_prod_q;

    assign shamt      = b_i[SHAMT_W-1:0];
    assign short_done = valid_i && !exec_pkg::op_is_long(op_i);
    assign mul_lo     = a_i * b_i; // truncated to XLEN by the assignment.

    // stage one datapath.
    always_comb begin
        case (op_i)
            exec_pkg::ADD: short_result = a_i + b_i;
            exec_pkg::SUB: short_result = a_i - b_i;
            exec_pkg::AND: short_result = a_i & b_i;
            exec_pkg::OR:  short_result = a_i | b_i;
            exec_pkg::XOR: short_result = a_i ^ b_i;
            exec_pkg::SLL: short_result = a_i << shamt;
            exec_pkg::SRL: short_result = a_i >> shamt;
            default:       short_result = '0; // MUL goes through stage two.
        endcase
    end

    // stage two, the registered product.
    always_ff @(posedge clk_i) begin
        if (!rstn_i) begin
            mul_valid_q <= 1'b0;
        end else begin
            mul_valid_q <= valid_i && exec_pkg::op_is_long(op_i);
        end
    end

    always_ff @(posedge clk_i) begin
        if (valid_i && exec_pkg::op_is_long(op_i)) begin
            mul_prod_q <= mul_lo;
            mul_dst_q  <= dst_i;
        end
    end

    // output register, fed by whichever stage completes.
    always_ff @(posedge clk_i) begin
        if (!rstn_i) begin
            res_valid_o <= 1'b0;
        end else begin
            res_valid_o <= mul_valid_q || short_done;
        end
    end

    always_ff @(posedge clk_i) begin
        if (mul_valid_q) begin
            res_dst_o  <= mul_dst_q;
            res_data_o <= mul_prod_q;
        end else if (short_done) begin
            res_dst_o  <= dst_i;
            res_data_o <= short_result;
        end
    end

    // a short op issued right after a multiply to this lane would collide.
    a_no_stage_clash: assert property (@(posedge clk_i) disable iff (!rstn_i)
        !(mul_valid_q && short_done))
        else $error("single-cycle op issued one cycle after MUL on the same lane");

endmodule

`default_nettype wire

//--- rtl/exec_cluster.sv
// integer execute cluster, top level.
//  - operand fetch with lane steering.
//  - physical register file, one write port per lane.
//  - NUM_LANES ALU lanes and the writeback unit.
`timescale 1ns/1ps
`default_nettype none

module exec_cluster #(
    parameter int NUM_LANES = 2,
    parameter int NUM_PREGS = 64,
    localparam int PREG_W   = $clog2(NUM_PREGS),
    localparam int LANE_W   = (NUM_LANES > 1) ? $clog2(NUM_LANES) : 1
) (
    input  logic                                     clk_i,
    input  logic                                     rstn_i,
    // issue port.
    input  logic                                     issue_valid_i,
    input  exec_pkg::alu_op_t                        issue_op_i,
    input  logic [LANE_W-1:0]                        issue_lane_i,
    input  logic [PREG_W-1:0]                        issue_src1_i,
    input  logic [PREG_W-1:0]                        issue_src2_i,
    input  logic [PREG_W-1:0]                        issue_dst_i,
    // completion port, one per lane.
    output logic [NUM_LANES-1:0]                     complete_valid_o,
    output logic [NUM_LANES-1:0][PREG_W-1:0]         complete_dst_o,
    output logic [NUM_LANES-1:0][exec_pkg::XLEN-1:0] complete_data_o
);

    logic [PREG_W-1:0]                        rf_addr1;
    logic [PREG_W-1:0]                        rf_addr2;
    logic [exec_pkg::XLEN-1:0]                rf_data1;
    logic [exec_pkg::XLEN-1:0]                rf_data2;

    logic [NUM_LANES-1:0]                     lane_valid;
    exec_pkg::alu_op_t [NUM_LANES-1:0]        lane_op;
    logic [NUM_LANES-1:0][exec_pkg::XLEN-1:0] lane_a;
    logic [NUM_LANES-1:0][exec_pkg::XLEN-1:0] lane_b;
    logic [NUM_LANES-1:0][PREG_W-1:0]         lane_dst;

    logic [NUM_LANES-1:0]                     res_valid;
    logic [NUM_LANES-1:0][PREG_W-1:0]         res_dst;
    logic [NUM_LANES-1:0][exec_pkg::XLEN-1:0] res_data;

    logic [NUM_LANES-1:0]                     wb_enable;
    logic [NUM_LANES-1:0][PREG_W-1:0]         wb_addr;
    logic [NUM_LANES-1:0][exec_pkg::XLEN-1:0] wb_data;

    operand_fetch #(
        .NUM_LANES (NUM_LANES),
        .NUM_PREGS (NUM_PREGS)
    ) fetch_i (
        .clk_i         (clk_i),
        .rstn_i        (rstn_i),
        .issue_valid_i (issue_valid_i),
        .issue_op_i    (issue_op_i),
        .issue_lane_i  (issue_lane_i),
        .issue_src1_i  (issue_src1_i),
        .issue_src2_i  (issue_src2_i),
        .issue_dst_i   (issue_dst_i),
        .rf_addr1_o    (rf_addr1),
        .rf_addr2_o    (rf_addr2),
        .rf_data1_i    (rf_data1),
        .rf_data2_i    (rf_data2),
        .lane_valid_o  (lane_valid),
        .lane_op_o     (lane_op),
        .lane_a_o      (lane_a),
        .lane_b_o      (lane_b),
        .lane_dst_o    (lane_dst)
    );

    phys_regfile #(
        .NUM_PREGS (NUM_PREGS),
        .NUM_WB    (NUM_LANES) // one write port per lane.
    ) regfile_i (
        .clk_i          (clk_i),
        .rstn_i         (rstn_i),
        .write_enable_i (wb_enable),
        .write_addr_i   (wb_addr),
        .write_data_i   (wb_data),
        .read_addr1_i   (rf_addr1),
        .read_addr2_i   (rf_addr2),
        .read_data1_o   (rf_data1),
        .read_data2_o   (rf_data2)
    );

    for (genvar g = 0; g < NUM_LANES; g++) begin : g_lane
        alu_lane #(
            .NUM_PREGS (NUM_PREGS)
        ) lane_i (
            .clk_i       (clk_i),
            .rstn_i      (rstn_i),
            .valid_i     (lane_valid[g]),
            .op_i        (lane_op[g]),
            .a_i         (lane_a[g]),
            .b_i         (lane_b[g]),
            .dst_i       (lane_dst[g]),
            .res_valid_o (res_valid[g]),
            .res_dst_o   (res_dst[g]),
            .res_data_o  (res_data[g])
        );
    end

    writeback_unit #(
        .NUM_LANES (NUM_LANES),
        .NUM_PREGS (NUM_PREGS)
    ) wb_i (
        .clk_i            (clk_i),
        .rstn_i           (rstn_i),
        .res_valid_i      (res_valid),
        .res_dst_i        (res_dst),
        .res_data_i       (res_data),
        .wb_enable_o      (wb_enable),
        .wb_addr_o        (wb_addr),
        .wb_data_o        (wb_data),
        .complete_valid_o (complete_valid_o),
        .complete_dst_o   (complete_dst_o),
        .complete_data_o  (complete_data_o)
    );

endmodule

`default_nettype wire

//--- rtl/operand_fetch.sv
// operand fetch stage.
//  - drives the source indices into the register file.
//  - forces register 0 sources to zero.
//  - registers the instruction into the input slot of the selected lane.
`timescale 1ns/1ps
`default_nettype none

module operand_fetch #(
    parameter int NUM_LANES = 2,
    parameter int NUM_PREGS = 64,
    localparam int PREG_W   = $clog2(NUM_PREGS),
    localparam int LANE_W   = (NUM_LANES > 1) ? $clog2(NUM_LANES) : 1
) (
    input  logic                                     clk_i,
    input  logic                                     rstn_i,
    // renamed instruction, one per cycle at most.
    input  logic                                     issue_valid_i,
    input  exec_pkg::alu_op_t                        issue_op_i,
    input  logic [LANE_W-1:0]                        issue_lane_i,
    input  logic [PREG_W-1:0]                        issue_src1_i,
    input  logic [PREG_W-1:0]                        issue_src2_i,
    input  logic [PREG_W-1:0]                        issue_dst_i,
    // register file read ports.
    output logic [PREG_W-1:0]                        rf_addr1_o,
    output logic [PREG_W-1:0]                        rf_addr2_o,
    input  logic [exec_pkg::XLEN-1:0]                rf_data1_i,
    input  logic [exec_pkg::XLEN-1:0]                rf_data2_i,
    // per-lane input slots.
    output logic [NUM_LANES-1:0]                     lane_valid_o,
    output exec_pkg::alu_op_t [NUM_LANES-1:0]        lane_op_o,
    output logic [NUM_LANES-1:0][exec_pkg::XLEN-1:0] lane_a_o,
    output logic [NUM_LANES-1:0][exec_pkg::XLEN-1:0] lane_b_o,
    output logic [NUM_LANES-1:0][PREG_W-1:0]         lane_dst_o
);

    logic [exec_pkg::XLEN-1:0] opnd_a; // source 1 after the zero check.
    logic [exec_pkg::XLEN-1:0] opnd_b; // source 2 after the zero check.

    assign rf_addr1_o = issue_src1_i; // read in the issue cycle.
    assign rf_addr2_o = issue_src2_i;

    // register 0 never carries data, whatever the read port returns.
    assign opnd_a = (issue_src1_i == '0) ? '0 : rf_data1_i;
    assign opnd_b = (issue_src2_i == '0) ? '0 : rf_data2_i;

    // valid bits pulse for one cycle in the selected lane only.
    always_ff @(posedge clk_i) begin
        if (!rstn_i) begin
            lane_valid_o <= '0;
        end else begin
            for (int k = 0; k < NUM_LANES; k++) begin
                lane_valid_o[k] <= issue_valid_i && (issue_lane_i == LANE_W'(k));
            end
        end
    end

    // slot payload is loaded only when the lane is picked.
    always_ff @(posedge clk_i) begin
        for (int k = 0; k < NUM_LANES; k++) begin
            if (issue_valid_i && (issue_lane_i == LANE_W'(k))) begin
                lane_op_o[k]  <= issue_op_i;
                lane_a_o[k]   <= opnd_a;
                lane_b_o[k]   <= opnd_b;
                lane_dst_o[k] <= issue_dst_i;
            end
        end
    end

    // the sender picks an existing lane.
    a_lane_in_range: assert property (@(posedge clk_i) disable iff (!rstn_i)
        issue_valid_i |-> (int'(issue_lane_i) < NUM_LANES))
        else $error("issue to lane %0d, only %0d lanes", issue_lane_i, NUM_LANES);

endmodule

`default_nettype wire

//--- rtl/writeback_unit.sv
// writeback unit of the execute cluster.
//  - registers every lane result.
//  - drives one register file write port per lane.
//  - the same registered values leave as completion reports.
`timescale 1ns/1ps
`default_nettype none

module writeback_unit #(
    parameter int NUM_LANES = 2,
    parameter int NUM_PREGS = 64,
    localparam int PREG_W   = $clog2(NUM_PREGS)
) (
    input  logic                                     clk_i,
    input  logic                                     rstn_i,
    // lane result registers.
    input  logic [NUM_LANES-1:0]                     res_valid_i,
    input  logic [NUM_LANES-1:0][PREG_W-1:0]         res_dst_i,
    input  logic [NUM_LANES-1:0][exec_pkg::XLEN-1:0] res_data_i,
    // register file write ports, lane k on port k.
    output logic [NUM_LANES-1:0]                     wb_enable_o,
    output logic [NUM_LANES-1:0][PREG_W-1:0]         wb_addr_o,
    output logic [NUM_LANES-1:0][exec_pkg::XLEN-1:0] wb_data_o,
    // completion reports, one pulse per finished instruction.
    output logic [NUM_LANES-1:0]                     complete_valid_o,
    output logic [NUM_LANES-1:0][PREG_W-1:0]         complete_dst_o,
    output logic [NUM_LANES-1:0][exec_pkg::XLEN-1:0] complete_data_o
);

    logic [NUM_LANES-1:0]                     wb_valid_q;
    logic [NUM_LANES-1:0][PREG_W-1:0]         wb_dst_q;
    logic [NUM_LANES-1:0][exec_pkg::XLEN-1:0] wb_data_q;

    always_ff @(posedge clk_i) begin
        if (!rstn_i) begin
            wb_valid_q <= '0;
        end else begin
            wb_valid_q <= res_valid_i; // one-cycle pulse per result.
        end
    end

    // payload only moves with a valid result.
    always_ff @(posedge clk_i) begin
        for (int k = 0; k < NUM_LANES; k++) begin
            if (res_valid_i[k]) begin
                wb_dst_q[k]  <= res_dst_i[k];
                wb_data_q[k] <= res_data_i[k];
            end
        end
    end

    assign wb_enable_o      = wb_valid_q; // dst 0 is dropped by the regfile.
    assign wb_addr_o        = wb_dst_q;
    assign wb_data_o        = wb_data_q;

    assign complete_valid_o = wb_valid_q; // dst 0 still reports completion.
    assign complete_dst_o   = wb_dst_q;
    assign complete_data_o  = wb_data_q;

endmodule

`default_nettype wire
